// ==== project.f ====
mem_3r3w_pkg.sv
mem_delay_line.sv
sram_3r3w_model.sv
mem_3r3w_wrap.sv
mem_3r3w_top.sv
mem_3r3w_props.sv
mem_3r3w_checker.sv
tb_mem_3r3w.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the 3r3w memory testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_3r3w \
  -f project.f -o sim_tb \
  && ./obj_dir/sim_tb 2>&1 | tee sim.log \
  || echo "build or run error"

grep -q "SIMULATION PASSED" sim.log 2>/dev/null \
  && echo "result: pass" \
  || { echo "result: fail"; exit 1; }

// ==== tb_mem_3r3w.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mem_3r3w;

  import mem_3r3w_pkg::*;

  localparam int          t1_delay        = 1;
  localparam int          flopout         = 1;
  localparam int          lat             = t1_delay + flopout;
  localparam logic [31:0] lfsr_seed       = 32'h9b88b127;
  localparam logic [31:0] lfsr_taps       = 32'h80200003;
  localparam int          reset_cycles    = 10;
  localparam int          random_cycles   = 2000;
  localparam int          directed_cycles = 20 + 3 + 3 * 8 * 3 + 6 * (lat + 2);
  localparam int          timeout_cycles  = reset_cycles + directed_cycles + random_cycles + 200;

  logic         clk;
  logic         rst_n;
  rd_req_arr_t  rd_req;
  wr_req_arr_t  wr_req;
  rd_dout_arr_t rd_dout;
  rd_vld_t      rd_vld;

  rd_req_arr_t  rd_nxt;  // requests for the next edge
  wr_req_arr_t  wr_nxt;
  logic [31:0]  lfsr_state;
  int           cycle_cnt;
  int           err_mark;
  int           num_tests;
  int           failed_tests;

  mem_3r3w_top #(
    .t1_delay (t1_delay),
    .flopout  (flopout)
  ) u_mem_3r3w_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_req  (rd_req),
    .wr_req  (wr_req),
    .rd_dout (rd_dout),
    .rd_vld  (rd_vld)
  );

  mem_3r3w_checker #(
    .lat (lat)
  ) u_checker (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_req  (rd_req),
    .wr_req  (wr_req),
    .rd_dout (rd_dout),
    .rd_vld  (rd_vld)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  // galois lfsr, one step per bit
  function automatic logic [31:0] next_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ lfsr_taps) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  function automatic word_t rand_word();
    return word_t'(next_bits(mem_width));
  endfunction

  function automatic addr_t rand_window();
    return addr_t'(8'h80 | next_bits(3));  // 8 words, forces collisions
  endfunction

  function automatic int total_errors();
    return u_checker.err_cnt + u_mem_3r3w_top.u_sram.u_props.fail_cnt;
  endfunction

  task automatic set_read(input int p, input addr_t adr);
    rd_nxt[p].read = 1'b1;
    rd_nxt[p].adr  = adr;
  endtask

  task automatic set_write(input int p, input addr_t adr, input word_t din, input word_t bw);
    wr_nxt[p].write = 1'b1;
    wr_nxt[p].adr   = adr;
    wr_nxt[p].din   = din;
    wr_nxt[p].bw    = bw;
  endtask

  task automatic apply_cycle();
    @(posedge clk);
    rd_req <= rd_nxt;
    wr_req <= wr_nxt;
    rd_nxt = '0;
    wr_nxt = '0;
  endtask

  task automatic idle(input int n);
    repeat (n) apply_cycle();
  endtask

  task automatic end_test(input string name);
    int errs;
    idle(lat + 2);  // drain reads in flight
    errs = total_errors() - err_mark;
    num_tests++;
    if (errs != 0) begin
      failed_tests++;
    end
    $display("test %-12s %0d errors", name, errs);
    err_mark = total_errors();
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    rst_n        = 1'b0;
    rd_req       = '0;
    wr_req       = '0;
    rd_nxt       = '0;
    wr_nxt       = '0;
    lfsr_state   = lfsr_seed;
    cycle_cnt    = 0;
    err_mark     = 0;
    num_tests    = 0;
    failed_tests = 0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;

    idle(20);
    end_test("idle");

    for (int p = 0; p < num_wrprt; p++) begin
      set_write(p, addr_t'(8'h10 + p), rand_word(), '1);
    end
    apply_cycle();
    for (int r = 0; r < 2; r++) begin
      for (int p = 0; p < num_rdprt; p++) begin
        set_read(p, addr_t'(8'h10 + (p + r) % num_rdprt));
      end
      apply_cycle();
    end
    end_test("full_mask");

    for (int k = 0; k < 8; k++) begin
      set_write(k % 3, addr_t'(8'h20 + k), rand_word(), '1);
      apply_cycle();
      set_write((k + 1) % 3, addr_t'(8'h20 + k), rand_word(), rand_word());
      apply_cycle();
      set_read(k % 3, addr_t'(8'h20 + k));
      apply_cycle();
    end
    end_test("partial_mask");

    for (int k = 0; k < 8; k++) begin
      set_write(0, addr_t'(8'h40 + k), rand_word(), '1);
      apply_cycle();
      for (int p = 0; p < num_wrprt; p++) begin
        if (k % 2 == 1 || p != (k / 2) % 3) begin  // three writers on odd rounds
          set_write(p, addr_t'(8'h40 + k), rand_word(), rand_word());
        end
      end
      apply_cycle();
      for (int p = 0; p < num_rdprt; p++) begin
        set_read(p, addr_t'(8'h40 + k));
      end
      apply_cycle();
    end
    end_test("same_addr");

    for (int k = 0; k < 8; k++) begin
      set_write(0, addr_t'(8'h60 + k), rand_word(), '1);
      apply_cycle();
      set_read(k % 3, addr_t'(8'h60 + k));
      set_write((k + 1) % 3, addr_t'(8'h60 + k), rand_word(), '1);
      apply_cycle();
      set_read((k + 2) % 3, addr_t'(8'h60 + k));
      apply_cycle();
    end
    end_test("rd_wr_same");

    repeat (random_cycles) begin
      for (int p = 0; p < num_rdprt; p++) begin
        if (next_bits(1) != 0) begin
          set_read(p, rand_window());
        end
        if (next_bits(1) != 0) begin
          set_write(p, rand_window(), rand_word(), rand_word());
        end
      end
      apply_cycle();
    end
    end_test("random");

    $display("tests %0d, failed %0d, errors %0d", num_tests, failed_tests, total_errors());
    if (failed_tests == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mem_3r3w_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_3r3w_checker #(
  parameter int lat = 2
) (
  input wire                            clk,
  input wire                            rst_n,
  input wire mem_3r3w_pkg::rd_req_arr_t  rd_req,
  input wire mem_3r3w_pkg::wr_req_arr_t  wr_req,
  input wire mem_3r3w_pkg::rd_dout_arr_t rd_dout,
  input wire mem_3r3w_pkg::rd_vld_t      rd_vld
);

  import mem_3r3w_pkg::*;

  localparam int ring_len = 64;  // longer than any latency

  word_t       ref_mem   [mem_numaddr];
  word_t       ref_known [mem_numaddr];  // bits with defined contents
  logic        pend_vld  [num_rdprt][ring_len];
  word_t       pend_word [num_rdprt][ring_len];
  word_t       pend_mask [num_rdprt][ring_len];
  int unsigned cyc;
  int          err_cnt;

  initial begin
    cyc     = 0;
    err_cnt = 0;
    for (int i = 0; i < mem_numaddr; i++) begin
      ref_mem[i]   = '0;
      ref_known[i] = '0;
    end
    for (int p = 0; p < num_rdprt; p++) begin
      for (int s = 0; s < ring_len; s++) begin
        pend_vld[p][s]  = 1'b0;
        pend_word[p][s] = '0;
        pend_mask[p][s] = '0;
      end
    end
  end

  //////////////////////////////////////////////////
  // sampled mid-cycle, inputs and outputs settled
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    int    slot;
    addr_t a;
    word_t exp_w;
    word_t act_w;
    if (rst_n) begin
      // reads see the contents from before this edge's writes
      for (int p = 0; p < num_rdprt; p++) begin
        if (rd_req[p].read) begin
          slot = int'((cyc + lat) % ring_len);
          a    = rd_req[p].adr;
          pend_vld[p][slot]  = 1'b1;
          pend_word[p][slot] = ref_mem[a];
          pend_mask[p][slot] = ref_known[a];
        end
      end
      slot = int'(cyc % ring_len);
      for (int p = 0; p < num_rdprt; p++) begin
        exp_w = pend_word[p][slot] & pend_mask[p][slot];
        act_w = rd_dout[p] & pend_mask[p][slot];
        if (rd_vld[p] !== pend_vld[p][slot]) begin
          $display("FAIL t=%0t rd_vld[%0d] expected %b actual %b",
                   $time, p, pend_vld[p][slot], rd_vld[p]);
          err_cnt++;
        end else if (rd_vld[p] && (act_w !== exp_w)) begin
          $display("FAIL t=%0t rd_dout[%0d] expected %h actual %h",
                   $time, p, exp_w, act_w);
          err_cnt++;
        end
        pend_vld[p][slot] = 1'b0;
      end
      // port order, so the highest port wins per bit
      for (int p = 0; p < num_wrprt; p++) begin
        if (wr_req[p].write) begin
          a            = wr_req[p].adr;
          ref_mem[a]   = (ref_mem[a] & ~wr_req[p].bw) | (wr_req[p].din & wr_req[p].bw);
          ref_known[a] = ref_known[a] | wr_req[p].bw;
        end
      end
      cyc++;
    end
  end

endmodule

`default_nettype wire

// ==== mem_3r3w_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_3r3w_props #(
  parameter int t1_delay = 1
) (
  input wire                            clk,
  input wire                            rst_n,
  input wire mem_3r3w_pkg::rd_req_arr_t  t1_rd,
  input wire mem_3r3w_pkg::wr_req_arr_t  t1_wr,
  input wire mem_3r3w_pkg::rd_dout_arr_t t1_dout
);

  import mem_3r3w_pkg::*;

  word_t filled [mem_numaddr];  // bits written at least once
  int    fail_cnt;

  initial begin
    fail_cnt = 0;
    for (int i = 0; i < mem_numaddr; i++) begin
      filled[i] = '0;
    end
  end

  always @(posedge clk) begin
    for (int p = 0; p < num_wrprt; p++) begin
      if (t1_wr[p].write) begin
        filled[t1_wr[p].adr] <= filled[t1_wr[p].adr] | t1_wr[p].bw;
      end
    end
  end

  for (genvar i = 0; i < num_rdprt; i++) begin : g_rd
    a_dout_known: assert property (@(posedge clk) disable iff (!rst_n)
      t1_rd[i].read && (filled[t1_rd[i].adr] == '1) |-> ##t1_delay !$isunknown(t1_dout[i]))
      else begin
        $error("read data unknown on port %0d", i);
        fail_cnt++;
      end

    a_rd_req_known: assert property (@(posedge clk) disable iff (!rst_n)
      t1_rd[i].read |-> !$isunknown(t1_rd[i].adr))
      else begin
        $error("read address unknown on port %0d", i);
        fail_cnt++;
      end
  end

  for (genvar i = 0; i < num_wrprt; i++) begin : g_wr
    a_wr_req_known: assert property (@(posedge clk) disable iff (!rst_n)
      t1_wr[i].write |-> !$isunknown({t1_wr[i].adr, t1_wr[i].din, t1_wr[i].bw}))
      else begin
        $error("write request field unknown on port %0d", i);
        fail_cnt++;
      end
  end

endmodule

bind sram_3r3w_model mem_3r3w_props #(
  .t1_delay (t1_delay)
) u_props (
  .clk     (clk),
  .rst_n   (rst_n),
  .t1_rd   (t1_rd),
  .t1_wr   (t1_wr),
  .t1_dout (t1_dout)
);

`default_nettype wire

// ==== mem_3r3w_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_3r3w_top #(
  parameter int t1_delay = 1,  // macro read latency
  parameter int flopout  = 1   // wrapper output stages
) (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire mem_3r3w_pkg::rd_req_arr_t  rd_req,
  input  wire mem_3r3w_pkg::wr_req_arr_t  wr_req,
  output mem_3r3w_pkg::rd_dout_arr_t     rd_dout,
  output mem_3r3w_pkg::rd_vld_t          rd_vld
);

  import mem_3r3w_pkg::*;

  // wrapper to macro
  rd_req_arr_t  t1_rd;
  wr_req_arr_t  t1_wr;
  rd_dout_arr_t t1_dout;

  mem_3r3w_wrap #(
    .t1_delay (t1_delay),
    .flopout  (flopout)
  ) u_wrap (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_req  (rd_req),
    .wr_req  (wr_req),
    .rd_dout (rd_dout),
    .rd_vld  (rd_vld),
    .t1_rd   (t1_rd),
    .t1_wr   (t1_wr),
    .t1_dout (t1_dout)
  );

  sram_3r3w_model #(
    .t1_delay (t1_delay)
  ) u_sram (
    .clk     (clk),
    .rst_n   (rst_n),
    .t1_rd   (t1_rd),
    .t1_wr   (t1_wr),
    .t1_dout (t1_dout)
  );

endmodule

`default_nettype wire

// ==== mem_3r3w_wrap.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_3r3w_wrap #(
  parameter int t1_delay = 1,
  parameter int flopout  = 1
) (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire mem_3r3w_pkg::rd_req_arr_t  rd_req,
  input  wire mem_3r3w_pkg::wr_req_arr_t  wr_req,
  output mem_3r3w_pkg::rd_dout_arr_t     rd_dout,
  output mem_3r3w_pkg::rd_vld_t          rd_vld,
  output mem_3r3w_pkg::rd_req_arr_t      t1_rd,
  output mem_3r3w_pkg::wr_req_arr_t      t1_wr,
  input  wire mem_3r3w_pkg::rd_dout_arr_t t1_dout
);

  import mem_3r3w_pkg::*;

  rd_vld_t rd_issue;  // read strobes of this cycle

  //////////////////////////////////////////////////
  // logical to physical port map
  //////////////////////////////////////////////////

  // one to one, no banking
  always_comb begin
    for (int i = 0; i < num_rdprt; i++) begin
      t1_rd[i].read = rd_req[i].read;
      t1_rd[i].adr  = rd_req[i].adr;
      rd_issue[i]   = rd_req[i].read;
    end
    for (int i = 0; i < num_wrprt; i++) begin
      t1_wr[i].write = wr_req[i].write;
      t1_wr[i].adr   = wr_req[i].adr;
      t1_wr[i].din   = wr_req[i].din;
      t1_wr[i].bw    = wr_req[i].bw;
    end
  end

  //////////////////////////////////////////////////
  // output alignment
  //////////////////////////////////////////////////

  // valid covers macro latency and output flops
  mem_delay_line #(
    .payload_t (rd_vld_t),
    .depth     (t1_delay + flopout)
  ) u_vld_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .d     (rd_issue),
    .q     (rd_vld)
  );

  // data already carries the macro latency
  mem_delay_line #(
    .payload_t (rd_dout_arr_t),
    .depth     (flopout)
  ) u_dout_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .d     (t1_dout),
    .q     (rd_dout)
  );

endmodule

`default_nettype wire

// ==== sram_3r3w_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module sram_3r3w_model #(
  parameter int t1_delay = 1
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire mem_3r3w_pkg::rd_req_arr_t t1_rd,
  input  wire mem_3r3w_pkg::wr_req_arr_t t1_wr,
  output mem_3r3w_pkg::rd_dout_arr_t   t1_dout
);

  import mem_3r3w_pkg::*;

  word_t                 mem [mem_numaddr];  // storage, no reset
  rd_dout_arr_t          rd_word;            // array read, before delay
  word_t [num_wrprt-1:0] wr_merge;           // final word per write port

  //////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////

  // samples the contents from before this edge's writes
  always_comb begin
    for (int i = 0; i < num_rdprt; i++) begin
      if (t1_rd[i].read) begin
        rd_word[i] = mem[t1_rd[i].adr];
      end else begin
        rd_word[i] = '0;
      end
    end
  end

  mem_delay_line #(
    .payload_t (rd_dout_arr_t),
    .depth     (t1_delay)
  ) u_dout_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .d     (rd_word),
    .q     (t1_dout)
  );

  //////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////

  // Each writing port builds the complete new word for its address by applying
  // every port that hits the same address in port order. Ports sharing an
  // address therefore all store the same word, with the highest port winning
  // per bit.
  always_comb begin
    for (int p = 0; p < num_wrprt; p++) begin
      wr_merge[p] = mem[t1_wr[p].adr];
      for (int j = 0; j < num_wrprt; j++) begin
        if (t1_wr[j].write && (t1_wr[j].adr == t1_wr[p].adr)) begin
          wr_merge[p] = merge_bits(wr_merge[p], t1_wr[j].din, t1_wr[j].bw);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < num_wrprt; p++) begin
      if (t1_wr[p].write) begin
        mem[t1_wr[p].adr] <= wr_merge[p];
      end
    end
  end

endmodule

`default_nettype wire

// ==== mem_delay_line.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_delay_line #(
  parameter type payload_t = logic,
  parameter int  depth     = 1
) (
  input  wire      clk,
  input  wire      rst_n,
  input  wire      payload_t d,
  output payload_t q
);

  generate
    if (depth == 0) begin : g_bypass
      assign q = d;  // zero latency
    end else begin : g_pipe
      payload_t stage [depth];

      always_ff @(posedge clk) begin
        if (!rst_n) begin
          for (int i = 0; i < depth; i++) begin
            stage[i] <= '0;
          end
        end else begin
          stage[0] <= d;
          for (int i = 1; i < depth; i++) begin
            stage[i] <= stage[i-1];  // shift toward q
          end
        end
      end

      assign q = stage[depth-1];
    end
  endgenerate

endmodule

`default_nettype wire

// ==== mem_3r3w_pkg.sv ====
`default_nettype none

package mem_3r3w_pkg;

  //////////////////////////////////////////////////
  // geometry of the 3r3w macro
  //////////////////////////////////////////////////

  localparam int mem_width   = 15;  // data word
  localparam int mem_bitaddr = 8;
  localparam int mem_numaddr = 256;

  localparam int num_rdprt = 3;  // fixed by the macro
  localparam int num_wrprt = 3;

  typedef logic [mem_width-1:0]   word_t;  // data and bit-write mask
  typedef logic [mem_bitaddr-1:0] addr_t;

  //////////////////////////////////////////////////
  // per-port requests
  //////////////////////////////////////////////////

  typedef struct packed {
    logic  read;
    addr_t adr;
  } rd_req_t;

  typedef struct packed {
    logic  write;
    addr_t adr;
    word_t din;
    word_t bw;   // 1 = bit is written
  } wr_req_t;

  // port arrays, index is the port number
  typedef rd_req_t [num_rdprt-1:0] rd_req_arr_t;
  typedef wr_req_t [num_wrprt-1:0] wr_req_arr_t;
  typedef word_t   [num_rdprt-1:0] rd_dout_arr_t;
  typedef logic    [num_rdprt-1:0] rd_vld_t;

  // masked write of one port over a word
  function automatic word_t merge_bits(word_t old_word, word_t din, word_t bw);
    merge_bits = (old_word & ~bw) | (din & bw);
  endfunction

endpackage

`default_nettype wire
